//--- Makefile
SRCS = $(wildcard hdl/*.sv) $(wildcard tests/*.sv)

obj_dir/Vllc_set_front_tb: $(SRCS) list.f
	verilator --binary --timing --timescale 1ns/100ps -f list.f \
		--top-module llc_set_front_tb -Mdir obj_dir

run: obj_dir/Vllc_set_front_tb
	@out="$$(./obj_dir/Vllc_set_front_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- hdl/input_arbiter.sv
`timescale 1ns/100ps

module input_arbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             rsp_in_valid,
    input  logic             req_in_valid,
    input  logic             dma_in_valid,
    input  llc_pkg::msg_in_t dma_in,
    input  logic             advance,
    input  logic             rst_stall,
    input  logic             flush_stall,
    input  logic             req_stall,
    input  logic             dma_active,
    input  logic             dma_write,
    output llc_pkg::sel_t    sel,
    output logic             rsp_in_ready,
    output logic             req_in_ready,
    output logic             dma_in_ready
);

    logic req_ok;
    logic req_window;   // A request lookup went out on the last edge.

    // Downstream flags a conflicting request in the first cycle it is visible.
    // The next request waits out that cycle so it cannot slip past the stall.
    assign req_ok = req_in_valid & ~req_stall & ~req_window;

    // Fixed priority: walks, response, request, DMA burst, new DMA request.
    always_comb begin
        sel = '0;
        if (rst_stall) begin
            sel.rst_resume = 1'b1;
        end else if (flush_stall) begin
            sel.flush_resume = 1'b1;
        end else if (rsp_in_valid) begin
            sel.rsp_get = 1'b1;
        end else if (req_ok) begin
            sel.req_get = 1'b1;
        end else if (dma_active) begin
            // Burst in progress, keeps its own direction.
            sel.dma_write_resume = dma_write;
            sel.dma_read_resume  = ~dma_write;
        end else if (dma_in_valid) begin
            sel.dma_req_get      = 1'b1;
            sel.dma_write_resume = dma_in.write;   // First line takes the request's direction.
            sel.dma_read_resume  = ~dma_in.write;
        end
    end

    // A channel is only taken on an edge that really advances.
    assign rsp_in_ready = advance & sel.rsp_get;
    assign req_in_ready = advance & sel.req_get;
    assign dma_in_ready = advance & sel.dma_req_get;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_window <= 1'b0;
        end else begin
            req_window <= advance & sel.req_get;
        end
    end

endmodule

//--- hdl/llc_pkg.sv
package llc_pkg;

    // Address geometry of the last-level cache.
    localparam int ADDR_BITS      = 32;
    localparam int OFFSET_BITS    = 4;                             // 16-byte lines.
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int LLC_SET_BITS   = 4;                             // 16 sets.
    localparam int LLC_TAG_BITS   = LINE_ADDR_BITS - LLC_SET_BITS;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [LLC_SET_BITS-1:0]   llc_set_t;
    typedef logic [LLC_TAG_BITS-1:0]   llc_tag_t;

    // Tag sits above set, so a line address casts straight into this.
    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
    } line_breakdown_llc_t;

    // What the tag pipeline is asked to do with a lookup.
    typedef enum logic [2:0] {
        RSP        = 3'd0,
        REQ        = 3'd1,
        DMA_READ   = 3'd2,
        DMA_WRITE  = 3'd3,
        FLUSH_WALK = 3'd4,
        RST_WALK   = 3'd5
    } lookup_kind_e;

    // Payload shared by the response, request and DMA channels.
    typedef struct packed {
        line_addr_t addr;
        logic       write;
    } msg_in_t;

    // Source picked for this cycle.
    // A new DMA burst also raises the flag of its direction.
    typedef struct packed {
        logic rsp_get;
        logic req_get;
        logic dma_req_get;
        logic dma_read_resume;
        logic dma_write_resume;
        logic flush_resume;
        logic rst_resume;
    } sel_t;

    typedef struct packed {
        lookup_kind_e        kind;
        line_breakdown_llc_t line_br;
    } lookup_t;

endpackage

//--- hdl/llc_set_front.sv
`timescale 1ns/100ps

module llc_set_front #(
    parameter int DMA_MAX_LINES = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  llc_pkg::msg_in_t                     rsp_in,
    input  logic                                 rsp_in_valid,
    input  llc_pkg::msg_in_t                     req_in,
    input  logic                                 req_in_valid,
    input  llc_pkg::msg_in_t                     dma_in,
    input  logic                                 dma_in_valid,
    input  logic [$clog2(DMA_MAX_LINES + 1)-1:0] dma_lines,
    input  logic                                 flush_start,
    input  logic                                 stall_notice,
    input  logic                                 lookup_ready,
    output logic                                 rsp_in_ready,
    output logic                                 req_in_ready,
    output logic                                 dma_in_ready,
    output llc_pkg::lookup_t                     lookup_out,
    output logic                                 lookup_valid
);

    import llc_pkg::*;

    sel_t                sel;
    logic                advance;
    logic                stall_hit;
    logic                rst_stall;
    logic                flush_stall;
    logic                req_stall;
    logic                dma_active;
    logic                dma_write;
    llc_set_t            rst_flush_stalled_set;
    llc_set_t            req_in_stalled_set;
    llc_tag_t            req_in_stalled_tag;
    line_addr_t          dma_addr;
    line_breakdown_llc_t line_br;
    llc_set_t            set;
    lookup_kind_e        kind;
    lookup_kind_e        kind_q;
    logic                incr_rst_flush_stalled_set;
    logic                clr_rst_stall;
    logic                clr_flush_stall;
    logic                clr_req_stall;
    logic                update_dma_addr_from_req;

    // Move on when there is work and the output slot is free or draining.
    assign advance   = (sel != '0) & (~lookup_valid | lookup_ready);
    assign stall_hit = stall_notice & lookup_valid;   // Only a visible lookup can stall.

    input_arbiter input_arbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .rsp_in_valid (rsp_in_valid),
        .req_in_valid (req_in_valid),
        .dma_in_valid (dma_in_valid),
        .dma_in       (dma_in),
        .advance      (advance),
        .rst_stall    (rst_stall),
        .flush_stall  (flush_stall),
        .req_stall    (req_stall),
        .dma_active   (dma_active),
        .dma_write    (dma_write),
        .sel          (sel),
        .rsp_in_ready (rsp_in_ready),
        .req_in_ready (req_in_ready),
        .dma_in_ready (dma_in_ready)
    );

    read_set read_set_inst (
        .clk                        (clk),
        .rst                        (rst),
        .rd_set_en                  (advance),
        .sel                        (sel),
        .rsp_in_addr                (rsp_in.addr),
        .req_in_addr                (req_in.addr),
        .dma_req_in_addr            (dma_in.addr),
        .dma_addr                   (dma_addr),
        .rst_flush_stalled_set      (rst_flush_stalled_set),
        .req_in_stalled_set         (req_in_stalled_set),
        .req_in_stalled_tag         (req_in_stalled_tag),
        .req_stall                  (req_stall),
        .line_br                    (line_br),
        .set                        (set),
        .kind                       (kind),
        .incr_rst_flush_stalled_set (incr_rst_flush_stalled_set),
        .clr_rst_stall              (clr_rst_stall),
        .clr_flush_stall            (clr_flush_stall),
        .clr_req_stall              (clr_req_stall),
        .update_dma_addr_from_req   (update_dma_addr_from_req)
    );

    stall_tracker #(
        .DMA_MAX_LINES (DMA_MAX_LINES)
    ) stall_tracker_inst (
        .clk                        (clk),
        .rst                        (rst),
        .advance                    (advance),
        .sel                        (sel),
        .flush_start                (flush_start),
        .stall_notice               (stall_hit),
        .stall_line                 (lookup_out.line_br),
        .dma_in                     (dma_in),
        .dma_lines                  (dma_lines),
        .incr_rst_flush_stalled_set (incr_rst_flush_stalled_set),
        .clr_rst_stall              (clr_rst_stall),
        .clr_flush_stall            (clr_flush_stall),
        .clr_req_stall              (clr_req_stall),
        .update_dma_addr_from_req   (update_dma_addr_from_req),
        .rst_stall                  (rst_stall),
        .flush_stall                (flush_stall),
        .rst_flush_stalled_set      (rst_flush_stalled_set),
        .req_stall                  (req_stall),
        .req_in_stalled_tag         (req_in_stalled_tag),
        .req_in_stalled_set         (req_in_stalled_set),
        .dma_addr                   (dma_addr),
        .dma_active                 (dma_active),
        .dma_write                  (dma_write)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_valid <= 1'b0;
        end else if (advance) begin
            lookup_valid <= 1'b1;
        end else if (lookup_ready) begin
            lookup_valid <= 1'b0;   // Drained with nothing behind it.
        end
    end

    // Kind is loaded on the same edge as the line breakdown in read_set.
    always_ff @(posedge clk) begin
        if (advance) begin
            kind_q <= kind;
        end
    end

    assign lookup_out.kind        = kind_q;
    assign lookup_out.line_br.tag = line_br.tag;
    assign lookup_out.line_br.set = set;

endmodule

//--- hdl/read_set.sv
`timescale 1ns/100ps

module read_set (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rd_set_en,
    input  llc_pkg::sel_t                sel,
    input  llc_pkg::line_addr_t          rsp_in_addr,
    input  llc_pkg::line_addr_t          req_in_addr,
    input  llc_pkg::line_addr_t          dma_req_in_addr,
    input  llc_pkg::line_addr_t          dma_addr,
    input  llc_pkg::llc_set_t            rst_flush_stalled_set,
    input  llc_pkg::llc_set_t            req_in_stalled_set,
    input  llc_pkg::llc_tag_t            req_in_stalled_tag,
    input  logic                         req_stall,
    output llc_pkg::line_breakdown_llc_t line_br,
    output llc_pkg::llc_set_t            set,
    output llc_pkg::lookup_kind_e        kind,
    output logic                         incr_rst_flush_stalled_set,
    output logic                         clr_rst_stall,
    output logic                         clr_flush_stall,
    output logic                         clr_req_stall,
    output logic                         update_dma_addr_from_req
);

    import llc_pkg::*;

    line_addr_t          addr_for_set;
    line_breakdown_llc_t line_br_next;
    logic                walk;
    logic                last_set;

    always_comb begin
        walk     = sel.rst_resume | sel.flush_resume;
        last_set = (rst_flush_stalled_set == {LLC_SET_BITS{1'b1}});

        // Address of the chosen source, same priority as the arbiter.
        addr_for_set             = '0;
        update_dma_addr_from_req = 1'b0;
        if (sel.rsp_get) begin
            addr_for_set = rsp_in_addr;
        end else if (sel.req_get) begin
            addr_for_set = req_in_addr;
        end else if (sel.dma_req_get) begin
            addr_for_set             = dma_req_in_addr;
            update_dma_addr_from_req = 1'b1;
        end else if (sel.dma_read_resume || sel.dma_write_resume) begin
            addr_for_set             = dma_addr;
            update_dma_addr_from_req = 1'b1;
        end

        line_br_next = line_breakdown_llc_t'(addr_for_set);
        if (walk) begin
            line_br_next.tag = '0;                     // Walks visit a set, not a line.
            line_br_next.set = rst_flush_stalled_set;
        end

        kind = DMA_READ;
        if (sel.rst_resume) kind = RST_WALK;
        else if (sel.flush_resume) kind = FLUSH_WALK;
        else if (sel.rsp_get) kind = RSP;
        else if (sel.req_get) kind = REQ;
        else if (sel.dma_write_resume) kind = DMA_WRITE;

        // Walk bookkeeping. Each walk ends on the last set.
        incr_rst_flush_stalled_set = walk;
        clr_rst_stall              = sel.rst_resume & last_set;
        clr_flush_stall            = sel.flush_resume & last_set;

        // A response to the stalled line frees the request path.
        clr_req_stall = sel.rsp_get & req_stall
                        & (line_br_next.tag == req_in_stalled_tag)
                        & (line_br_next.set == req_in_stalled_set);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_br <= '0;
        end else if (rd_set_en) begin
            line_br <= line_br_next;
        end
    end

    assign set = line_br.set;   // Set handed to the tag pipeline.

endmodule

//--- hdl/stall_tracker.sv
`timescale 1ns/100ps

module stall_tracker #(
    parameter  int DMA_MAX_LINES = 8,
    localparam int CNT_BITS      = $clog2(DMA_MAX_LINES + 1)
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         advance,
    input  llc_pkg::sel_t                sel,
    input  logic                         flush_start,
    input  logic                         stall_notice,
    input  llc_pkg::line_breakdown_llc_t stall_line,
    input  llc_pkg::msg_in_t             dma_in,
    input  logic [CNT_BITS-1:0]          dma_lines,
    input  logic                         incr_rst_flush_stalled_set,
    input  logic                         clr_rst_stall,
    input  logic                         clr_flush_stall,
    input  logic                         clr_req_stall,
    input  logic                         update_dma_addr_from_req,
    output logic                         rst_stall,
    output logic                         flush_stall,
    output llc_pkg::llc_set_t            rst_flush_stalled_set,
    output logic                         req_stall,
    output llc_pkg::llc_tag_t            req_in_stalled_tag,
    output llc_pkg::llc_set_t            req_in_stalled_set,
    output llc_pkg::line_addr_t          dma_addr,
    output logic                         dma_active,
    output logic                         dma_write
);

    logic [CNT_BITS-1:0] dma_left;   // Lines of the burst still to be issued.
    logic                walk_step;
    logic                dma_step;

    assign walk_step = advance & incr_rst_flush_stalled_set;
    assign dma_step  = advance & update_dma_addr_from_req;

    // Reset and flush walks share one set counter.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall             <= 1'b1;   // Every set is walked once out of reset.
            flush_stall           <= 1'b0;
            rst_flush_stalled_set <= '0;
        end else begin
            if (walk_step) begin
                if (clr_rst_stall || clr_flush_stall) begin
                    rst_flush_stalled_set <= '0;
                end else begin
                    rst_flush_stalled_set <= rst_flush_stalled_set + 1'b1;
                end
            end
            if (walk_step && clr_rst_stall) begin
                rst_stall <= 1'b0;
            end
            // A new flush request wins over the end of a running one.
            if (flush_start) begin
                flush_stall <= 1'b1;
            end else if (walk_step && clr_flush_stall) begin
                flush_stall <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall <= 1'b0;
        end else if (stall_notice) begin
            req_stall <= 1'b1;
        end else if (advance && clr_req_stall) begin
            req_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_notice) begin
            req_in_stalled_tag <= stall_line.tag;
            req_in_stalled_set <= stall_line.set;
        end
    end

    // Burst control. The accepted request already issues the first line.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_active <= 1'b0;
            dma_write  <= 1'b0;
            dma_left   <= '0;
        end else if (dma_step) begin
            if (sel.dma_req_get) begin
                dma_active <= (dma_lines > 1);
                dma_write  <= dma_in.write & (dma_lines > 1);
                dma_left   <= dma_lines - 1'b1;
            end else begin
                dma_left <= dma_left - 1'b1;
                if (dma_left == 1) begin
                    dma_active <= 1'b0;   // Last line issued.
                    dma_write  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dma_step) begin
            dma_addr <= (sel.dma_req_get ? dma_in.addr : dma_addr) + 1'b1;
        end
    end

endmodule

//--- list.f
hdl/llc_pkg.sv
hdl/input_arbiter.sv
hdl/read_set.sv
hdl/stall_tracker.sv
hdl/llc_set_front.sv
tests/llc_set_front_tb.sv

//--- tests/llc_set_front_tb.sv
`timescale 1ns/100ps

module llc_set_front_tb;

    import llc_pkg::*;

    localparam int DRAIN_LIMIT = 400;   // Cycles allowed for one scenario to finish.
    localparam int SRC_NONE    = 0;
    localparam int SRC_WALK    = 1;
    localparam int SRC_RSP     = 2;
    localparam int SRC_REQ     = 3;
    localparam int SRC_DMA_RES = 4;
    localparam int SRC_DMA_NEW = 5;

    // One row of the stimulus table.
    typedef struct packed {
        logic [3:0]  n_rsp;
        logic [3:0]  n_req;
        logic [3:0]  n_dma;
        logic [3:0]  dma_lines;
        logic        dma_write;
        logic        flush;
        logic        stall_req;    // Stall the first request lookup seen.
        logic [15:0] ready_pat;    // lookup_ready per cycle, bit 0 first.
        logic [7:0]  exp_lookups;
    } scenario_t;

    logic        clk;
    logic        rst;
    msg_in_t     rsp_in;
    logic        rsp_in_valid;
    msg_in_t     req_in;
    logic        req_in_valid;
    msg_in_t     dma_in;
    logic        dma_in_valid;
    logic [3:0]  dma_lines;
    logic        flush_start;
    logic        stall_notice;
    logic        lookup_ready;
    logic        rsp_in_ready;
    logic        req_in_ready;
    logic        dma_in_ready;
    lookup_t     lookup_out;
    logic        lookup_valid;

    // Channel contents still to be offered.
    msg_in_t     rsp_q[$];
    msg_in_t     req_q[$];
    msg_in_t     dma_q[$];
    logic [3:0]  lines_q[$];
    msg_in_t     pend_rsp;
    int          rsp_delay;
    logic        stall_armed;
    logic        flush_pending;
    logic [15:0] cur_pat;
    logic [3:0]  pat_idx;
    logic [31:0] seed;
    int          seen;

    // Reference model state.
    logic                m_rst;
    logic                m_flush;
    llc_set_t            m_walk_set;
    logic                m_req_stall;
    logic                m_req_window;
    line_breakdown_llc_t m_stall_line;
    int                  m_dma_left;
    line_addr_t          m_dma_addr;
    logic                m_dma_write;
    logic                m_out_valid;
    lookup_t             m_out;

    llc_set_front #(
        .DMA_MAX_LINES (8)
    ) llc_set_front_inst (
        .clk          (clk),
        .rst          (rst),
        .rsp_in       (rsp_in),
        .rsp_in_valid (rsp_in_valid),
        .req_in       (req_in),
        .req_in_valid (req_in_valid),
        .dma_in       (dma_in),
        .dma_in_valid (dma_in_valid),
        .dma_lines    (dma_lines),
        .flush_start  (flush_start),
        .stall_notice (stall_notice),
        .lookup_ready (lookup_ready),
        .rsp_in_ready (rsp_in_ready),
        .req_in_ready (req_in_ready),
        .dma_in_ready (dma_in_ready),
        .lookup_out   (lookup_out),
        .lookup_valid (lookup_valid)
    );

    always #20 clk = ~clk;

    function automatic scenario_t scenario_row(input int idx);
        scenario_t r;
        case (idx)
            0: r = '{4'd1, 4'd1, 4'd0, 4'd0, 1'b0, 1'b0, 1'b0, 16'hFFFF, 8'd18};  // Reset walk.
            1: r = '{4'd1, 4'd1, 4'd1, 4'd1, 1'b0, 1'b0, 1'b0, 16'hFFFF, 8'd3};
            2: r = '{4'd0, 4'd3, 4'd0, 4'd0, 1'b0, 1'b0, 1'b1, 16'hFFFF, 8'd6};
            3: r = '{4'd0, 4'd0, 4'd1, 4'd5, 1'b1, 1'b0, 1'b0, 16'hFFFF, 8'd5};
            4: r = '{4'd0, 4'd0, 4'd1, 4'd8, 1'b0, 1'b0, 1'b0, 16'hFFFF, 8'd8};
            5: r = '{4'd2, 4'd1, 4'd0, 4'd0, 1'b0, 1'b1, 1'b0, 16'hFFFF, 8'd19};  // Flush.
            6: r = '{4'd2, 4'd2, 4'd2, 4'd3, 1'b0, 1'b0, 1'b0, 16'hF00F, 8'd10};
            7: r = '{4'd3, 4'd3, 4'd1, 4'd4, 1'b1, 1'b0, 1'b1, 16'hA5A5, 8'd13};
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_msg(output msg_in_t m);
        seed    = lcg_next(seed);
        m.addr  = seed[31:4];
        m.write = seed[15];
    endtask

    // Tag is the upper part of the line address, set the lowest bits.
    function automatic lookup_t make_lookup(input lookup_kind_e k, input line_addr_t a);
        lookup_t l;
        l.kind        = k;
        l.line_br.tag = a[LINE_ADDR_BITS-1:LLC_SET_BITS];
        l.line_br.set = a[LLC_SET_BITS-1:0];
        return l;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_lookup(input lookup_t got, input lookup_t exp);
        if (got !== exp) begin
            $display("ERR %0t: lookup_out kind %0d tag %h set %h, expected kind %0d tag %h set %h",
                     $time, got.kind, got.line_br.tag, got.line_br.set,
                     exp.kind, exp.line_br.tag, exp.line_br.set);
            abort_run();
        end
    endtask

    task automatic check_kind(input lookup_kind_e got, input lookup_kind_e exp);
        if (got !== exp) begin
            $display("ERR %0t: lookup kind %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input int scen);
        if (got != exp) begin
            $display("ERR %0t: scenario %0d gave %0d lookups, expected %0d", $time, scen, got, exp);
            abort_run();
        end
    endtask

    // Acts as the downstream pipeline and feeds the channels, 2 ns after the edge.
    task automatic drive_inputs();
        msg_in_t other;
        if (rsp_delay > 0) begin
            rsp_delay--;
            // Responses to other lines come first and must not free the request path.
            other = pend_rsp;
            if (rsp_delay == 2) begin
                other.addr[LINE_ADDR_BITS-1] = ~other.addr[LINE_ADDR_BITS-1];   // Other tag.
                rsp_q.push_back(other);
            end
            if (rsp_delay == 1) begin
                other.addr[0] = ~other.addr[0];   // Other set.
                rsp_q.push_back(other);
            end
            if (rsp_delay == 0) rsp_q.push_back(pend_rsp);   // Response to the stalled line.
        end
        stall_notice = 1'b0;
        if (stall_armed && lookup_valid && lookup_out.kind == REQ) begin
            stall_notice  = 1'b1;
            stall_armed   = 1'b0;
            pend_rsp.addr = {lookup_out.line_br.tag, lookup_out.line_br.set};
            pend_rsp.write = 1'b0;
            rsp_delay     = 3;
        end
        rsp_in_valid = (rsp_q.size() != 0);
        rsp_in       = rsp_in_valid ? rsp_q[0] : '0;
        req_in_valid = (req_q.size() != 0);
        req_in       = req_in_valid ? req_q[0] : '0;
        dma_in_valid = (dma_q.size() != 0);
        dma_in       = dma_in_valid ? dma_q[0] : '0;
        dma_lines    = dma_in_valid ? lines_q[0] : 4'd0;
        flush_start  = flush_pending;
        flush_pending = 1'b0;
        lookup_ready = cur_pat[pat_idx];
        pat_idx      = pat_idx + 1'b1;
    endtask

    // Checks the DUT at mid cycle, then steps the model over the coming edge.
    task automatic model_cycle();
        int      src;
        logic    clr_stall;
        lookup_t nxt;
        clr_stall = 1'b0;
        nxt       = '0;
        if (m_rst || m_flush) src = SRC_WALK;
        else if (rsp_in_valid) src = SRC_RSP;
        else if (req_in_valid && !m_req_stall && !m_req_window) src = SRC_REQ;
        else if (m_dma_left > 0) src = SRC_DMA_RES;
        else if (dma_in_valid) src = SRC_DMA_NEW;
        else src = SRC_NONE;
        if (m_out_valid && !lookup_ready) src = SRC_NONE;   // Output slot still full.

        check_bit(lookup_valid, m_out_valid, "lookup_valid");
        if (m_out_valid) begin
            check_kind(lookup_out.kind, m_out.kind);
            check_lookup(lookup_out, m_out);
        end
        check_bit(rsp_in_ready, src == SRC_RSP, "rsp_in_ready");
        check_bit(req_in_ready, src == SRC_REQ, "req_in_ready");
        check_bit(dma_in_ready, src == SRC_DMA_NEW, "dma_in_ready");
        if (lookup_valid && lookup_ready) seen++;

        case (src)
            SRC_WALK: begin
                nxt = make_lookup(m_rst ? RST_WALK : FLUSH_WALK, line_addr_t'(m_walk_set));
                if (m_walk_set == 4'hF) begin
                    if (m_rst) m_rst = 1'b0;
                    else m_flush = 1'b0;
                end
                m_walk_set = m_walk_set + 1'b1;   // Wraps to set 0 after the last set.
            end
            SRC_RSP: begin
                nxt       = make_lookup(RSP, rsp_in.addr);
                clr_stall = m_req_stall && (nxt.line_br == m_stall_line);
                void'(rsp_q.pop_front());
            end
            SRC_REQ: begin
                nxt = make_lookup(REQ, req_in.addr);
                void'(req_q.pop_front());
            end
            SRC_DMA_RES: begin
                nxt        = make_lookup(m_dma_write ? DMA_WRITE : DMA_READ, m_dma_addr);
                m_dma_addr = m_dma_addr + 1'b1;
                m_dma_left--;
            end
            SRC_DMA_NEW: begin
                nxt         = make_lookup(dma_in.write ? DMA_WRITE : DMA_READ, dma_in.addr);
                m_dma_addr  = dma_in.addr + 1'b1;
                m_dma_left  = int'(dma_lines) - 1;
                m_dma_write = dma_in.write;
                void'(dma_q.pop_front());
                void'(lines_q.pop_front());
            end
            default: ;
        endcase

        if (flush_start) m_flush = 1'b1;
        if (stall_notice && m_out_valid) begin
            m_req_stall  = 1'b1;
            m_stall_line = m_out.line_br;
        end else if (clr_stall) begin
            m_req_stall = 1'b0;
        end
        m_req_window = (src == SRC_REQ);   // Downstream gets one cycle to flag a conflict.
        if (src != SRC_NONE) begin
            m_out_valid = 1'b1;
            m_out       = nxt;
        end else if (lookup_ready) begin
            m_out_valid = 1'b0;
        end
    endtask

    task automatic step_cycle();
        drive_inputs();
        @(negedge clk);
        model_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic logic all_idle();
        return rsp_q.size() == 0 && req_q.size() == 0 && dma_q.size() == 0
               && rsp_delay == 0 && !flush_pending && !m_rst && !m_flush
               && m_dma_left == 0 && !m_out_valid;
    endfunction

    initial begin
        scenario_t row;
        msg_in_t   m;
        int        wait_cnt;
        clk           = 1'b0;
        rst           = 1'b0;
        rsp_in        = '0;
        rsp_in_valid  = 1'b0;
        req_in        = '0;
        req_in_valid  = 1'b0;
        dma_in        = '0;
        dma_in_valid  = 1'b0;
        dma_lines     = 4'd0;
        flush_start   = 1'b0;
        stall_notice  = 1'b0;
        lookup_ready  = 1'b0;
        seed          = 32'h97fa5a28;
        rsp_delay     = 0;
        pend_rsp      = '0;
        stall_armed   = 1'b0;
        flush_pending = 1'b0;
        cur_pat       = 16'hFFFF;
        pat_idx       = 4'd0;
        seen          = 0;
        m_rst         = 1'b1;   // DUT walks all sets out of reset.
        m_flush       = 1'b0;
        m_walk_set    = '0;
        m_req_stall   = 1'b0;
        m_req_window  = 1'b0;
        m_stall_line  = '0;
        m_dma_left    = 0;
        m_dma_addr    = '0;
        m_dma_write   = 1'b0;
        m_out_valid   = 1'b0;
        m_out         = '0;

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;

        for (int i = 0; i < 8; i++) begin
            row = scenario_row(i);
            repeat (row.n_rsp) begin
                draw_msg(m);
                rsp_q.push_back(m);
            end
            repeat (row.n_req) begin
                draw_msg(m);
                req_q.push_back(m);
            end
            repeat (row.n_dma) begin
                draw_msg(m);
                m.write = row.dma_write;
                dma_q.push_back(m);
                lines_q.push_back(row.dma_lines);
            end
            flush_pending = row.flush;
            stall_armed   = row.stall_req;
            cur_pat       = row.ready_pat;
            pat_idx       = 4'd0;
            seen          = 0;
            wait_cnt      = 0;
            step_cycle();
            while (!all_idle()) begin
                step_cycle();
                wait_cnt++;
                if (wait_cnt > DRAIN_LIMIT) begin
                    $display("Timeout: scenario %0d did not finish within %0d cycles",
                             i, DRAIN_LIMIT);
                    abort_run();
                end
            end
            check_count(seen, int'(row.exp_lookups), i);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
